/* include/rs_cfg.svh */
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

// bank size, a power of two
`define RS_ENTRIES 8

// reorder buffer index width
`define ROB_IDX_W 5

// physical register tag width
`define PREG_IDX_W 6

// result broadcast ports
`define CDB_PORTS 2

`endif

/* hw/rs_pkg.sv */
`include "rs_cfg.svh"

package rs_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_MUL,
        ALU_MULH,
        ALU_MULHSU,
        ALU_MULHU
    } alu_func_e;

    // one waiting instruction, 31 bits
    typedef struct packed {
        logic [`ROB_IDX_W-1:0]  rob_idx;
        logic [`PREG_IDX_W-1:0] prega;
        logic [`PREG_IDX_W-1:0] pregb;
        logic [`PREG_IDX_W-1:0] pdest;
        alu_func_e              alu_func;
        logic                   rd_mem;
        logic                   wr_mem;
        logic                   cond_branch;
        logic                   uncond_branch;
    } rs_payload_t;

    typedef struct packed {
        logic                   valid;
        logic [`PREG_IDX_W-1:0] tag;
    } cdb_t;

    // execution class, at most one bit set per entry
    typedef struct packed {
        logic alu;
        logic mult;
        logic br;
        logic load;
        logic store;
    } fu_ready_t;

endpackage

/* hw/rs_priority_pick.sv */
`timescale 1ns/10ps
`include "rs_cfg.svh"

// tree of two-input pickers, the highest-indexed requester wins
module rs_priority_pick #(
    parameter int NUM_BITS = `RS_ENTRIES
) (
    input  logic [NUM_BITS-1:0] req,
    input  logic                en,
    output logic [NUM_BITS-1:0] gnt
);

    // heap order: node 1 is the root, leaves sit at NUM_BITS..2*NUM_BITS-1
    logic [2*NUM_BITS-1:1] node_req;
    logic [2*NUM_BITS-1:1] node_en;

    assign node_en[1] = en;

    generate
        for (genvar k = 1; k < NUM_BITS; k++) begin : g_node
            assign node_req[k] = node_req[2*k] | node_req[2*k+1];

            // upper child beats lower child
            assign node_en[2*k+1] = node_en[k] & node_req[2*k+1];
            assign node_en[2*k]   = node_en[k] & node_req[2*k] & ~node_req[2*k+1];
        end

        for (genvar i = 0; i < NUM_BITS; i++) begin : g_leaf
            assign node_req[NUM_BITS+i] = req[i];
            assign gnt[i]               = node_en[NUM_BITS+i];
        end
    endgenerate

    // a grant exists exactly when enabled with any request pending
    always_comb begin
        assert #0 ($onehot0(gnt) && ((|gnt) == (en && node_req[1])))
            else $error("rs_priority_pick: bad grant %b for req %b en %b", gnt, req, en);
    end

endmodule

/* hw/rs_entry.sv */
`timescale 1ns/10ps
`include "rs_cfg.svh"

module rs_entry import rs_pkg::*; (
    input  logic                       clock,
    input  logic                       reset,

    input  logic                       alloc,
    input  rs_payload_t                dispatch_payload,
    input  logic                       prega_ready,
    input  logic                       pregb_ready,

    input  cdb_t [`CDB_PORTS-1:0]      cdb,
    input  logic                       grant,

    output logic                       busy,
    output rs_payload_t                payload,
    output fu_ready_t                  ready
);

    logic src_a_rdy;
    logic src_b_rdy;
    logic match_a;
    logic match_b;
    logic src_a_ok;
    logic src_b_ok;
    logic is_mult;

    // tag compare against every broadcast port
    always_comb begin
        match_a = 1'b0;
        match_b = 1'b0;
        for (int p = 0; p < `CDB_PORTS; p++) begin
            match_a = match_a | (cdb[p].valid && (cdb[p].tag == payload.prega));
            match_b = match_b | (cdb[p].valid && (cdb[p].tag == payload.pregb));
        end
    end

    // wakeup is combinational, a match counts this cycle
    assign src_a_ok = src_a_rdy | match_a;
    assign src_b_ok = src_b_rdy | match_b;

    assign is_mult = (payload.alu_func inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU});

    always_comb begin
        ready = '0;
        if (busy && src_a_ok && src_b_ok) begin
            if (payload.wr_mem) begin
                ready.store = 1'b1;
            end else if (payload.rd_mem) begin
                ready.load = 1'b1;
            end else if (is_mult) begin
                ready.mult = 1'b1;
            end else if (payload.cond_branch || payload.uncond_branch) begin
                ready.br = 1'b1;
            end else begin
                ready.alu = 1'b1; // everything else
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy      <= 1'b0;
            src_a_rdy <= 1'b0;
            src_b_rdy <= 1'b0;
        end else if (alloc) begin
            busy      <= 1'b1;
            src_a_rdy <= prega_ready;
            src_b_rdy <= pregb_ready;
        end else if (busy) begin
            busy      <= !grant; // freed at the edge after issue
            src_a_rdy <= src_a_ok;
            src_b_rdy <= src_b_ok;
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            payload <= dispatch_payload;
        end
    end

    // allocator only picks free entries
    alloc_free_a: assert property (
        @(posedge clock) disable iff (reset)
        alloc |-> !busy
    ) else $error("rs_entry: alloc while busy");

    // issue grant must come from a ready entry
    grant_ready_a: assert property (
        @(posedge clock) disable iff (reset)
        grant |-> (busy && (|ready))
    ) else $error("rs_entry: grant to an entry that is not ready");

endmodule

/* hw/rs_issue_select.sv */
`timescale 1ns/10ps
`include "rs_cfg.svh"

module rs_issue_select import rs_pkg::*; (
    input  fu_ready_t   [`RS_ENTRIES-1:0] entry_ready,
    input  rs_payload_t [`RS_ENTRIES-1:0] entry_payload,
    input  logic                          issue_stall,
    input  logic                          load_issue_stall,

    output logic [`RS_ENTRIES-1:0]        issue_grant,
    output logic                          issue_valid,
    output rs_payload_t                   issue_payload,
    output fu_ready_t                     issue_class,
    output logic                          store_issue_stall
);

    localparam int IDX_W = $clog2(`RS_ENTRIES);

    logic [`RS_ENTRIES-1:0] alu_req;
    logic [`RS_ENTRIES-1:0] mult_req;
    logic [`RS_ENTRIES-1:0] br_req;
    logic [`RS_ENTRIES-1:0] load_req;
    logic [`RS_ENTRIES-1:0] store_req;
    logic [`RS_ENTRIES-1:0] alu_gnt;
    logic [`RS_ENTRIES-1:0] mult_gnt;
    logic [`RS_ENTRIES-1:0] br_gnt;
    logic [`RS_ENTRIES-1:0] load_gnt;
    logic [`RS_ENTRIES-1:0] store_gnt;
    logic [`RS_ENTRIES-1:0] class_pick;
    logic [IDX_W-1:0]       issue_idx;

    // per-class request vectors across the entries
    always_comb begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            alu_req[i]   = entry_ready[i].alu;
            mult_req[i]  = entry_ready[i].mult;
            br_req[i]    = entry_ready[i].br;
            load_req[i]  = entry_ready[i].load;
            store_req[i] = entry_ready[i].store;
        end
    end

    rs_priority_pick alu_pick (.req(alu_req), .en(!issue_stall), .gnt(alu_gnt));
    rs_priority_pick mult_pick (.req(mult_req), .en(!issue_stall), .gnt(mult_gnt));
    rs_priority_pick br_pick (.req(br_req), .en(!issue_stall), .gnt(br_gnt));
    rs_priority_pick store_pick (.req(store_req), .en(!issue_stall), .gnt(store_gnt));
    rs_priority_pick load_pick (
        .req (load_req),
        .en  (!issue_stall && !load_issue_stall),
        .gnt (load_gnt)
    );

    assign class_pick = alu_gnt | mult_gnt | br_gnt | load_gnt | store_gnt;

    // one issue per cycle over the class winners
    rs_priority_pick final_pick (.req(class_pick), .en(!issue_stall), .gnt(issue_grant));

    always_comb begin
        issue_idx = '0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (issue_grant[i]) begin
                issue_idx = IDX_W'(i);
            end
        end
    end

    assign issue_valid   = |issue_grant;
    assign issue_payload = issue_valid ? entry_payload[issue_idx] : '0;
    assign issue_class   = issue_valid ? entry_ready[issue_idx] : '0; // zero when idle

    // loads hold off behind an issuing store
    assign store_issue_stall = issue_class.store;

endmodule

/* hw/rs_bank.sv */
`timescale 1ns/10ps
`include "rs_cfg.svh"

module rs_bank import rs_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  dispatch_en,
    input  rs_payload_t           dispatch_payload,
    input  logic                  prega_ready,
    input  logic                  pregb_ready,

    input  cdb_t [`CDB_PORTS-1:0] cdb,

    input  logic                  issue_stall,
    input  logic                  load_issue_stall,

    output logic                  issue_valid,
    output rs_payload_t           issue_payload,
    output fu_ready_t             issue_class,
    output logic                  store_issue_stall,
    output logic                  rs_full
);

    logic [`RS_ENTRIES-1:0]        entry_busy;
    logic [`RS_ENTRIES-1:0]        entry_alloc;
    logic [`RS_ENTRIES-1:0]        issue_grant;
    fu_ready_t [`RS_ENTRIES-1:0]   entry_ready;
    rs_payload_t [`RS_ENTRIES-1:0] entry_payload;

    // highest free slot takes the dispatch
    rs_priority_pick alloc_pick (
        .req (~entry_busy),
        .en  (dispatch_en),
        .gnt (entry_alloc)
    );

    generate
        for (genvar i = 0; i < `RS_ENTRIES; i++) begin : g_entry
            rs_entry entry_i (
                .clock            (clock),
                .reset            (reset),
                .alloc            (entry_alloc[i]),
                .dispatch_payload (dispatch_payload),
                .prega_ready      (prega_ready),
                .pregb_ready      (pregb_ready),
                .cdb              (cdb),
                .grant            (issue_grant[i]),
                .busy             (entry_busy[i]),
                .payload          (entry_payload[i]),
                .ready            (entry_ready[i])
            );
        end
    endgenerate

    rs_issue_select issue_sel (
        .entry_ready       (entry_ready),
        .entry_payload     (entry_payload),
        .issue_stall       (issue_stall),
        .load_issue_stall  (load_issue_stall),
        .issue_grant       (issue_grant),
        .issue_valid       (issue_valid),
        .issue_payload     (issue_payload),
        .issue_class       (issue_class),
        .store_issue_stall (store_issue_stall)
    );

    assign rs_full = &entry_busy;

    // dispatch side must honour back-pressure
    no_dispatch_full_a: assert property (
        @(posedge clock) disable iff (reset)
        dispatch_en |-> !rs_full
    ) else $error("rs_bank: dispatch while full");

endmodule

/* verif/rs_bank_tb.sv */
`timescale 1ns/10ps
`include "rs_cfg.svh"

module rs_bank_tb import rs_pkg::*; ();

    localparam int CLK_PERIOD    = 4;
    localparam int DRIVE_DELAY   = 1;
    localparam int RESET_CYCLES  = 16;
    localparam int DRAIN_CYCLES  = 64;
    localparam int RAND_CYCLES   = 60;
    localparam int TEST_CYCLES   = 10 + (16 + DRAIN_CYCLES) + (RAND_CYCLES + DRAIN_CYCLES)
                                 + (24 + DRAIN_CYCLES) + (12 + DRAIN_CYCLES) + (4 + DRAIN_CYCLES);
    localparam int MARGIN_CYCLES = 100;
    localparam int N             = `RS_ENTRIES;

    logic                  clock;
    logic                  reset;
    logic                  dispatch_en;
    rs_payload_t           dispatch_payload;
    logic                  prega_ready;
    logic                  pregb_ready;
    cdb_t [`CDB_PORTS-1:0] cdb;
    logic                  issue_stall;
    logic                  load_issue_stall;
    logic                  issue_valid;
    rs_payload_t           issue_payload;
    fu_ready_t             issue_class;
    logic                  store_issue_stall;
    logic                  rs_full;

    // reference model of the entries
    logic [N-1:0] m_busy;
    logic [N-1:0] m_ra;
    logic [N-1:0] m_rb;
    logic [N-1:0] ok_a;
    logic [N-1:0] ok_b;
    rs_payload_t  m_pay [N];
    fu_ready_t    m_cls [N];
    int           exp_idx;
    int           alloc_idx;
    logic         exp_valid;
    rs_payload_t  exp_payload;
    fu_ready_t    exp_class;

    int err_count;
    int tests_run;

    rs_bank rs_bank_i (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("sim failed");
        $finish;
    end

    // store, load, multiply, branch, alu in that order
    function automatic fu_ready_t class_of(rs_payload_t p);
        fu_ready_t c;
        c = '0;
        if (p.wr_mem) c.store = 1'b1;
        else if (p.rd_mem) c.load = 1'b1;
        else if (p.alu_func == ALU_MUL || p.alu_func == ALU_MULH ||
                 p.alu_func == ALU_MULHSU || p.alu_func == ALU_MULHU) c.mult = 1'b1;
        else if (p.cond_branch || p.uncond_branch) c.br = 1'b1;
        else c.alu = 1'b1;
        return c;
    endfunction

    always_comb begin : model_comb
        logic hit_a;
        logic hit_b;
        exp_idx   = -1;
        alloc_idx = -1;
        for (int i = 0; i < N; i++) begin
            hit_a = 1'b0;
            hit_b = 1'b0;
            for (int p = 0; p < `CDB_PORTS; p++) begin
                hit_a = hit_a | (cdb[p].valid && cdb[p].tag == m_pay[i].prega);
                hit_b = hit_b | (cdb[p].valid && cdb[p].tag == m_pay[i].pregb);
            end
            ok_a[i]  = m_ra[i] | hit_a;
            ok_b[i]  = m_rb[i] | hit_b;
            m_cls[i] = (m_busy[i] && ok_a[i] && ok_b[i]) ? class_of(m_pay[i]) : '0;
            if ((|m_cls[i]) && !issue_stall && !(m_cls[i].load && load_issue_stall))
                exp_idx = i; // later index wins
            if (!m_busy[i])
                alloc_idx = i;
        end
        if (!dispatch_en || (&m_busy))
            alloc_idx = -1;
        exp_valid   = (exp_idx >= 0);
        exp_payload = exp_valid ? m_pay[exp_idx] : '0;
        exp_class   = exp_valid ? m_cls[exp_idx] : '0;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            m_busy <= '0;
            m_ra   <= '0;
            m_rb   <= '0;
        end else begin
            for (int i = 0; i < N; i++) begin
                if (i == alloc_idx) begin
                    m_busy[i] <= 1'b1;
                    m_pay[i]  <= dispatch_payload;
                    m_ra[i]   <= prega_ready;
                    m_rb[i]   <= pregb_ready;
                end else if (m_busy[i]) begin
                    m_busy[i] <= (i != exp_idx);
                    m_ra[i]   <= ok_a[i];
                    m_rb[i]   <= ok_b[i];
                end
            end
        end
    end

    task automatic report_err(string msg);
        $display("ERR %0t: %s", $time, msg);
        err_count++;
    endtask

    valid_a: assert property (@(posedge clock) disable iff (reset) issue_valid == exp_valid)
        else report_err($sformatf("issue_valid %b, model %b", issue_valid, exp_valid));
    payload_a: assert property (@(posedge clock) disable iff (reset)
        exp_valid |-> issue_payload == exp_payload)
        else report_err($sformatf("issue_payload %h, model %h", issue_payload, exp_payload));
    class_a: assert property (@(posedge clock) disable iff (reset) issue_class == exp_class)
        else report_err($sformatf("issue_class %b, model %b", issue_class, exp_class));
    onehot_a: assert property (@(posedge clock) disable iff (reset)
        issue_valid |-> $onehot(issue_class))
        else report_err($sformatf("issue_class %b not one-hot", issue_class));
    stall_a: assert property (@(posedge clock) disable iff (reset) issue_stall |-> !issue_valid)
        else report_err("issue under issue_stall");
    load_stall_a: assert property (@(posedge clock) disable iff (reset)
        load_issue_stall |-> !issue_class.load)
        else report_err("load issued under load_issue_stall");
    store_flag_a: assert property (@(posedge clock) disable iff (reset)
        store_issue_stall == (exp_valid && exp_class.store))
        else report_err($sformatf("store_issue_stall %b, model %b", store_issue_stall,
                                  exp_valid && exp_class.store));
    full_a: assert property (@(posedge clock) disable iff (reset) rs_full == (&m_busy))
        else report_err($sformatf("rs_full %b, model busy %b", rs_full, m_busy));

    task automatic next_cycle();
        @(posedge clock);
        #(DRIVE_DELAY);
    endtask

    task automatic clear_inputs();
        dispatch_en      = 1'b0;
        prega_ready      = 1'b0;
        pregb_ready      = 1'b0;
        cdb              = '0;
        issue_stall      = 1'b0;
        load_issue_stall = 1'b0;
    endtask

    task automatic dispatch_one(rs_payload_t pay, logic ra, logic rb);
        dispatch_en      = 1'b1;
        dispatch_payload = pay;
        prega_ready      = ra;
        pregb_ready      = rb;
    endtask

    function automatic rs_payload_t random_payload();
        rs_payload_t p;
        int kind;
        kind            = $urandom_range(0, 5);
        p.rob_idx       = 5'($urandom);
        p.prega         = 6'($urandom_range(0, 15));
        p.pregb         = 6'($urandom_range(0, 15));
        p.pdest         = 6'($urandom);
        p.alu_func      = alu_func_e'($urandom_range(0, 13));
        p.wr_mem        = (kind == 0);
        p.rd_mem        = (kind == 1) || (kind == 0 && $urandom_range(0, 1) == 1);
        p.cond_branch   = (kind == 2);
        p.uncond_branch = (kind == 3) || ($urandom_range(0, 7) == 0); // overlaps other kinds
        return p;
    endfunction

    // kind 0 alu, 1 load, 2 store
    function automatic rs_payload_t shaped_payload(int kind);
        rs_payload_t p;
        p               = random_payload();
        p.alu_func      = ALU_ADD;
        p.cond_branch   = 1'b0;
        p.uncond_branch = 1'b0;
        p.rd_mem        = (kind == 1);
        p.wr_mem        = (kind == 2);
        return p;
    endfunction

    // sweep all tags on the cdb until the model is empty
    task automatic drain(string name);
        int n;
        n = 0;
        clear_inputs();
        while (m_busy != '0 && n < DRAIN_CYCLES) begin
            cdb[0].valid = 1'b1;
            cdb[0].tag   = 6'(2 * n);
            cdb[1].valid = 1'b1;
            cdb[1].tag   = 6'(2 * n + 1);
            next_cycle();
            n++;
        end
        cdb = '0;
        if (m_busy != '0) begin
            $display("%s: bank still holds entries after %0d drain cycles", name, DRAIN_CYCLES);
            err_count++;
        end
        tests_run++;
        $display("test %s done, errors so far %0d", name, err_count);
    endtask

    initial begin
        rs_payload_t pay;
        int idx;
        void'($urandom(32'hd3c8_31fc));
        err_count        = 0;
        tests_run        = 0;
        reset            = 1'b1;
        dispatch_payload = '0;
        clear_inputs();
        repeat (RESET_CYCLES) @(posedge clock);
        #(DRIVE_DELAY);
        reset = 1'b0;

        if (issue_valid || issue_class != '0 || store_issue_stall || rs_full)
            report_err("outputs not idle after reset");
        for (int n = 0; n < 8; n++) begin
            cdb[0].valid = 1'($urandom);
            cdb[0].tag   = 6'($urandom);
            next_cycle();
        end
        drain("after_reset");

        for (int i = 0; i < N; i++) begin
            pay       = random_payload();
            pay.prega = 6'(16 + i);
            pay.pregb = 6'(32 + i);
            dispatch_one(pay, 1'b0, 1'b0);
            next_cycle();
        end
        dispatch_en = 1'b0;
        if (!rs_full)
            report_err("rs_full low after eight dispatches");
        for (int k = 0; k < N; k++) begin
            idx          = (k * 5) % N; // scrambled wake order
            cdb[0].valid = 1'b1;
            cdb[0].tag   = 6'(16 + idx);
            cdb[1].valid = 1'b1;
            cdb[1].tag   = 6'(32 + idx);
            issue_stall  = (k < 4);
            next_cycle();
        end
        drain("fill_order");

        for (int n = 0; n < RAND_CYCLES; n++) begin
            if (!(&m_busy) && $urandom_range(0, 3) != 0)
                dispatch_one(random_payload(), $urandom_range(0, 3) != 0,
                             $urandom_range(0, 3) != 0);
            else
                dispatch_en = 1'b0;
            cdb[0].valid     = 1'($urandom);
            cdb[0].tag       = 6'($urandom_range(0, 15));
            cdb[1].valid     = 1'($urandom);
            cdb[1].tag       = 6'($urandom_range(0, 15));
            issue_stall      = ($urandom_range(0, 7) == 0);
            load_issue_stall = ($urandom_range(0, 3) == 0);
            next_cycle();
        end
        drain("classification");

        issue_stall = 1'b1;
        for (int i = 0; i < 6; i++) begin
            dispatch_one(shaped_payload(i % 2 == 0 ? 1 : 0), 1'b1, 1'b1);
            next_cycle();
        end
        dispatch_en = 1'b0;
        repeat (4) next_cycle();
        issue_stall      = 1'b0;
        load_issue_stall = 1'b1; // alus drain, loads wait
        repeat (8) next_cycle();
        drain("stalls");

        for (int i = 0; i < 12; i++) begin
            if (!(&m_busy))
                dispatch_one(shaped_payload(2 - (i % 3)), 1'b1, 1'b1);
            else
                dispatch_en = 1'b0;
            next_cycle();
        end
        drain("store_flag");

        pay       = shaped_payload(0);
        pay.prega = 6'd40;
        pay.pregb = 6'd40;
        dispatch_one(pay, 1'b0, 1'b0);
        next_cycle();
        dispatch_en = 1'b0;
        next_cycle();
        cdb[1].valid = 1'b1;
        cdb[1].tag   = 6'd40;
        #(DRIVE_DELAY);
        if (!issue_valid || issue_payload != pay)
            report_err($sformatf("no same-cycle issue, valid %b payload %h", issue_valid,
                                 issue_payload));
        next_cycle();
        drain("same_cycle_wakeup");

        $display("tests run %0d, errors %0d", tests_run, err_count);
        if (err_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
hw/rs_pkg.sv
hw/rs_priority_pick.sv
hw/rs_entry.sv
hw/rs_issue_select.sv
hw/rs_bank.sv
verif/rs_bank_tb.sv

/* Makefile */
# Verilator build and run for the reservation-station bank

VERILATOR ?= verilator
TOP       ?= rs_bank_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -E '\.s?v$$' $(FILELIST))
HDRS    := $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

# pass only when the run prints the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)
